// File: logic/matmul_settings.svh
`ifndef MATMUL_SETTINGS_SVH
`define MATMUL_SETTINGS_SVH

// element width of A and B
`define MM_DWIDTH 16

// edge of one systolic tile
`define MM_TILE 4

// edge of the full matrices
`define MM_SIZE 8

// operand memory addressing
`define MM_AWIDTH 7
`define MM_MEM_DEPTH 128

// start sample to done
`define MM_LATENCY 16

`endif

// File: logic/matmul_pkg.sv
`default_nettype none

`include "matmul_settings.svh"

package matmul_pkg;

  // one operand element
  typedef logic [`MM_DWIDTH-1:0] element_t;

  // one result sum that wraps mod 2^32
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;

  // column k of A for one tile row with entry i for row 4r+i
  typedef element_t [`MM_TILE-1:0] a_slice_t;

  // row k of B for the four columns of a tile column
  typedef element_t [`MM_TILE-1:0] b_slice_t;

  // one 4x4 quadrant of C indexed by row and column
  typedef acc_t [`MM_TILE-1:0][`MM_TILE-1:0] result_block_t;

endpackage

`default_nettype wire

// File: logic/operand_if.sv
`timescale 1ns/10ps
`default_nettype none

interface operand_if;
  import matmul_pkg::*;

  a_slice_t a_slice;
  b_slice_t b_slice;
  logic     valid;
  logic     clear;

  modport source (
    output a_slice,
    output b_slice,
    output valid,
    output clear
  );

  modport sink (
    input a_slice,
    input b_slice,
    input valid,
    input clear
  );

endinterface

`default_nettype wire

// File: logic/operand_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module operand_ram #(
  parameter type word_t = matmul_pkg::a_slice_t
) (
  input  logic                  clk,
  input  logic [`MM_AWIDTH-1:0] addr,
  input  word_t                 d,
  input  logic                  we,
  output word_t                 q
);

  word_t mem [`MM_MEM_DEPTH];

  // q shows the old word on a write
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= d;
    end
    q <= mem[addr];
  end

endmodule

`default_nettype wire

// File: logic/operand_feeder.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module operand_feeder (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             enable_writing_to_mem,
  input  logic [`MM_TILE*`MM_DWIDTH-1:0]   data_pi,
  input  logic [`MM_AWIDTH-1:0]            addr_pi,
  input  logic                             we_a,
  input  logic                             we_b,
  input  logic                             start_mat_mul,
  operand_if.source                        ops [(`MM_SIZE/`MM_TILE)*(`MM_SIZE/`MM_TILE)]
);
  import matmul_pkg::*;

  localparam int GRID = `MM_SIZE / `MM_TILE;
  localparam int GW   = $clog2(GRID);
  localparam int KW   = $clog2(`MM_SIZE);
  localparam int CW   = $clog2(`MM_LATENCY);

  logic          busy;
  logic [CW-1:0] cnt;
  logic          start_ok;
  logic          valid_q;
  logic          clear_q;
  a_slice_t      a_q [GRID];
  b_slice_t      b_q [GRID];

  assign start_ok = start_mat_mul && !busy && !enable_writing_to_mem;

  // busy covers the whole run so a new start waits for done
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy    <= 1'b0;
      cnt     <= '0;
      valid_q <= 1'b0;
      clear_q <= 1'b0;
    end
    else
    begin
      clear_q <= start_ok;
      // data of step k comes back one cycle after its address
      valid_q <= busy && (cnt < CW'(`MM_SIZE));
      if (start_ok)
      begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy)
      begin
        cnt <= cnt + 1'b1;
        if (cnt == CW'(`MM_LATENCY - 1))
        begin
          busy <= 1'b0;
        end
      end
    end
  end

  // memory r holds tile row r of A and tile column r of B at 8r+k
  for (genvar r = 0; r < GRID; r++)
  begin : g_mem
    logic [`MM_AWIDTH-1:0] rd_addr;
    logic [`MM_AWIDTH-1:0] addr;
    logic                  sel;

    assign rd_addr = `MM_AWIDTH'(r * `MM_SIZE) | `MM_AWIDTH'(cnt[KW-1:0]);
    assign addr    = enable_writing_to_mem ? addr_pi : rd_addr;
    assign sel     = (addr_pi[KW +: GW] == GW'(r));

    operand_ram #(.word_t(a_slice_t)) u_a_ram (
      .clk  (clk),
      .addr (addr),
      .d    (a_slice_t'(data_pi)),
      .we   (we_a && sel),
      .q    (a_q[r])
    );

    operand_ram #(.word_t(b_slice_t)) u_b_ram (
      .clk  (clk),
      .addr (addr),
      .d    (b_slice_t'(data_pi)),
      .we   (we_b && sel),
      .q    (b_q[r])
    );
  end

  // tile t sits at tile row t/2, tile column t%2
  for (genvar t = 0; t < GRID * GRID; t++)
  begin : g_ops
    assign ops[t].a_slice = a_q[t / GRID];
    assign ops[t].b_slice = b_q[t % GRID];
    assign ops[t].valid   = valid_q;
    assign ops[t].clear   = clear_q;
  end

endmodule

`default_nettype wire

// File: logic/systolic_tile.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module systolic_tile (
  input  logic                      clk,
  input  logic                      reset,
  operand_if.sink                   ops,
  output matmul_pkg::result_block_t result,
  output logic                      done
);
  import matmul_pkg::*;

  localparam int N  = `MM_TILE;
  localparam int SW = $clog2(`MM_SIZE) + 1;

  // skewed edge inputs
  element_t a_row [N];
  element_t b_col [N];
  logic     v_row [N];

  // links between neighbouring PEs
  element_t a_reg [N][N-1];
  logic     v_reg [N][N-1];
  element_t b_reg [N-1][N];

  acc_t          acc [N][N];
  logic [SW-1:0] step_cnt;
  logic          v_last;

  // row i of A and column i of B delayed by i cycles
  for (genvar i = 0; i < N; i++)
  begin : g_skew
    if (i == 0)
    begin : g_direct
      assign a_row[i] = ops.a_slice[i];
      assign b_col[i] = ops.b_slice[i];
      assign v_row[i] = ops.valid;
    end
    else
    begin : g_line
      element_t a_line [i];
      element_t b_line [i];
      logic     v_line [i];

      always_ff @(posedge clk)
      begin
        a_line[0] <= ops.a_slice[i];
        b_line[0] <= ops.b_slice[i];
        for (int d = 1; d < i; d++)
        begin
          a_line[d] <= a_line[d-1];
          b_line[d] <= b_line[d-1];
        end
      end

      always_ff @(posedge clk)
      begin
        if (reset)
        begin
          v_line <= '{default: 1'b0};
        end
        else
        begin
          v_line[0] <= ops.valid;
          for (int d = 1; d < i; d++)
          begin
            v_line[d] <= v_line[d-1];
          end
        end
      end

      assign a_row[i] = a_line[i-1];
      assign b_col[i] = b_line[i-1];
      assign v_row[i] = v_line[i-1];
    end
  end

  // PE(i,j) sees step k at valid-cycle k+i+j
  for (genvar i = 0; i < N; i++)
  begin : g_pe_row
    for (genvar j = 0; j < N; j++)
    begin : g_pe
      element_t a_in;
      element_t b_in;
      logic     v_in;

      if (j == 0)
      begin : g_a_edge
        assign a_in = a_row[i];
        assign v_in = v_row[i];
      end
      else
      begin : g_a_link
        assign a_in = a_reg[i][j-1];
        assign v_in = v_reg[i][j-1];
      end

      if (i == 0)
      begin : g_b_edge
        assign b_in = b_col[j];
      end
      else
      begin : g_b_link
        assign b_in = b_reg[i-1][j];
      end

      // a and valid move right
      if (j < N - 1)
      begin : g_pass_a
        always_ff @(posedge clk)
        begin
          a_reg[i][j] <= a_in;
        end

        always_ff @(posedge clk)
        begin
          if (reset)
          begin
            v_reg[i][j] <= 1'b0;
          end
          else
          begin
            v_reg[i][j] <= v_in;
          end
        end
      end

      // b moves down
      if (i < N - 1)
      begin : g_pass_b
        always_ff @(posedge clk)
        begin
          b_reg[i][j] <= b_in;
        end
      end

      always_ff @(posedge clk)
      begin
        if (ops.clear)
        begin
          acc[i][j] <= '0;
        end
        else if (v_in)
        begin
          acc[i][j] <= acc[i][j] + acc_t'(a_in) * acc_t'(b_in);
        end
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < N; i++)
    begin
      for (int j = 0; j < N; j++)
      begin
        result[i][j] = acc[i][j];
      end
    end
  end

  // corner PE is the last to accept each step
  assign v_last = v_reg[N-1][N-2];

  always_ff @(posedge clk)
  begin
    if (reset || ops.clear)
    begin
      step_cnt <= '0;
      done     <= 1'b0;
    end
    else
    begin
      if (v_last && (step_cnt != SW'(`MM_SIZE)))
      begin
        step_cnt <= step_cnt + 1'b1;
      end
      done <= (step_cnt == SW'(`MM_SIZE));
    end
  end

endmodule

`default_nettype wire

// File: logic/result_drain.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module result_drain (
  input  logic                      clk,
  input  logic                      reset,
  input  matmul_pkg::result_block_t tile_results [(`MM_SIZE/`MM_TILE)*(`MM_SIZE/`MM_TILE)],
  input  logic [(`MM_SIZE/`MM_TILE)*(`MM_SIZE/`MM_TILE)-1:0] tile_done,
  input  logic [`MM_AWIDTH-1:0]     out_sel,
  output matmul_pkg::acc_t          data_out,
  output logic                      done_mat_mul
);

  localparam int LAST = `MM_SIZE * `MM_SIZE - 1;
  localparam int IW   = $clog2(`MM_SIZE * `MM_SIZE);
  localparam int TW   = $clog2(`MM_TILE);

  logic [IW-1:0]        idx;
  logic [IW-2*TW-1:0]   tile;
  logic [TW-1:0]        row;
  logic [TW-1:0]        col;

  assign done_mat_mul = &tile_done;

  // out of range selects the last element
  assign idx = (out_sel > `MM_AWIDTH'(LAST)) ? IW'(LAST) : out_sel[IW-1:0];

  // index is tile*16 + row*4 + col
  assign {tile, row, col} = idx;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      data_out <= '0;
    end
    else if (done_mat_mul)
    begin
      data_out <= tile_results[tile][row][col];
    end
  end

endmodule

`default_nettype wire

// File: logic/matmul_8x8.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module matmul_8x8 (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable_writing_to_mem,
  input  logic [`MM_TILE*`MM_DWIDTH-1:0] data_pi,
  input  logic [`MM_AWIDTH-1:0]          addr_pi,
  input  logic                           we_a,
  input  logic                           we_b,
  input  logic [`MM_AWIDTH-1:0]          out_sel,
  input  logic                           start_mat_mul,
  output matmul_pkg::acc_t               data_out,
  output logic                           done_mat_mul
);
  import matmul_pkg::*;

  localparam int NT = (`MM_SIZE / `MM_TILE) * (`MM_SIZE / `MM_TILE);

  result_block_t tile_results [NT];
  logic [NT-1:0] tile_done;

  // one operand link per tile
  operand_if ops [NT] ();

  operand_feeder u_feeder (
    .clk                   (clk),
    .reset                 (reset),
    .enable_writing_to_mem (enable_writing_to_mem),
    .data_pi               (data_pi),
    .addr_pi               (addr_pi),
    .we_a                  (we_a),
    .we_b                  (we_b),
    .start_mat_mul         (start_mat_mul),
    .ops                   (ops)
  );

  // quadrants C00, C01, C10, C11
  for (genvar t = 0; t < NT; t++)
  begin : g_tile
    systolic_tile u_tile (
      .clk    (clk),
      .reset  (reset),
      .ops    (ops[t]),
      .result (tile_results[t]),
      .done   (tile_done[t])
    );
  end

  result_drain u_drain (
    .clk          (clk),
    .reset        (reset),
    .tile_results (tile_results),
    .tile_done    (tile_done),
    .out_sel      (out_sel),
    .data_out     (data_out),
    .done_mat_mul (done_mat_mul)
  );

endmodule

`default_nettype wire

// File: testbench/matmul_8x8_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module matmul_8x8_asserts #(
  parameter int NT = (`MM_SIZE / `MM_TILE) * (`MM_SIZE / `MM_TILE)
) (
  input logic          clk,
  input logic          reset,
  input logic          clear,
  input logic [NT-1:0] valid,
  input logic          done_mat_mul
);

  a_reset_done: assert property (@(posedge clk) reset |=> !done_mat_mul)
    else $error("done_mat_mul high in the cycle after reset");

  // clear follows the edge that sampled start
  a_done_latency: assert property (@(posedge clk) disable iff (reset)
    clear |-> ##(`MM_LATENCY) $rose(done_mat_mul))
    else $error("done_mat_mul did not rise 16 cycles after start");

  for (genvar t = 0; t < NT; t++)
  begin : g_valid
    logic [3:0] run_len;

    always_ff @(posedge clk)
    begin
      if (reset || !valid[t])
      begin
        run_len <= '0;
      end
      else
      begin
        run_len <= run_len + 4'd1;
      end
    end

    a_valid_short: assert property (@(posedge clk) disable iff (reset)
      $fell(valid[t]) |-> run_len == 4'(`MM_SIZE))
      else $error("operand valid ended before eight cycles");

    a_valid_long: assert property (@(posedge clk) disable iff (reset)
      valid[t] |-> run_len < 4'(`MM_SIZE))
      else $error("operand valid lasted more than eight cycles");
  end

endmodule

bind matmul_8x8 matmul_8x8_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .clear        (ops[0].clear),
  .valid        ({ops[3].valid, ops[2].valid, ops[1].valid, ops[0].valid}),
  .done_mat_mul (done_mat_mul)
);

`default_nettype wire

// File: testbench/matmul_8x8_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_settings.svh"

module matmul_8x8_tb;

  localparam int N           = `MM_SIZE;
  localparam int T           = `MM_TILE;
  localparam int G           = `MM_SIZE / `MM_TILE;
  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = NUM_TESTS * 200;

  // fill patterns
  localparam int IDENT = 0;
  localparam int ONES  = 1;
  localparam int MAXV  = 2;
  localparam int RAND  = 3;
  localparam int ZERO  = 4;

  logic                           clk;
  logic                           reset;
  logic                           enable_writing_to_mem;
  logic [`MM_TILE*`MM_DWIDTH-1:0] data_pi;
  logic [`MM_AWIDTH-1:0]          addr_pi;
  logic                           we_a;
  logic                           we_b;
  logic [`MM_AWIDTH-1:0]          out_sel;
  logic                           start_mat_mul;
  logic [2*`MM_DWIDTH-1:0]        data_out;
  logic                           done_mat_mul;

  // test name, pattern of A, pattern of B
  string test_name [NUM_TESTS] = '{"identity_x_rand", "ones_x_ones", "max_x_max",
                                   "rand_x_rand", "zero_x_rand", "rand_x_identity"};
  int    a_pat [NUM_TESTS] = '{IDENT, ONES, MAXV, RAND, ZERO, RAND};
  int    b_pat [NUM_TESTS] = '{RAND, ONES, MAXV, RAND, RAND, IDENT};

  logic [15:0] ref_a [N][N];
  logic [15:0] ref_b [N][N];
  logic [31:0] ref_c [N][N];

  integer seed = 32'h2ae58118;
  int     errors;
  int     checks;
  int     cycles;
  int     lat;

  matmul_8x8 uut (
    .clk                   (clk),
    .reset                 (reset),
    .enable_writing_to_mem (enable_writing_to_mem),
    .data_pi               (data_pi),
    .addr_pi               (addr_pi),
    .we_a                  (we_a),
    .we_b                  (we_b),
    .out_sel               (out_sel),
    .start_mat_mul         (start_mat_mul),
    .data_out              (data_out),
    .done_mat_mul          (done_mat_mul)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [15:0] pattern_value(input int pat, input int row, input int col);
    case (pat)
      IDENT:   return (row == col) ? 16'd1 : 16'd0;
      ONES:    return 16'd1;
      MAXV:    return 16'hffff;
      RAND:    return 16'($random(seed));
      default: return 16'd0;
    endcase
  endfunction

  // reference product with sums wrapping at 32 bits
  task automatic build_model(input int ap, input int bp);
    logic [31:0] sum;
    for (int r = 0; r < N; r++)
    begin
      for (int c = 0; c < N; c++)
      begin
        ref_a[r][c] = pattern_value(ap, r, c);
        ref_b[r][c] = pattern_value(bp, r, c);
      end
    end
    for (int i = 0; i < N; i++)
    begin
      for (int j = 0; j < N; j++)
      begin
        sum = '0;
        for (int k = 0; k < N; k++)
        begin
          sum = sum + 32'(ref_a[i][k]) * 32'(ref_b[k][j]);
        end
        ref_c[i][j] = sum;
      end
    end
  endtask

  // A columns and B rows both go to 8g+k
  task automatic load_operands();
    logic [`MM_TILE*`MM_DWIDTH-1:0] word_a;
    logic [`MM_TILE*`MM_DWIDTH-1:0] word_b;
    @(posedge clk);
    enable_writing_to_mem <= 1'b1;
    for (int k = 0; k < N; k++)
    begin
      for (int g = 0; g < G; g++)
      begin
        for (int e = 0; e < T; e++)
        begin
          word_a[16*e +: 16] = ref_a[T*g+e][k];
          word_b[16*e +: 16] = ref_b[k][T*g+e];
        end
        addr_pi <= `MM_AWIDTH'(N*g + k);
        data_pi <= word_a;
        we_a    <= 1'b1;
        we_b    <= 1'b0;
        @(posedge clk);
        data_pi <= word_b;
        we_a    <= 1'b0;
        we_b    <= 1'b1;
        @(posedge clk);
      end
    end
    we_a                  <= 1'b0;
    we_b                  <= 1'b0;
    enable_writing_to_mem <= 1'b0;
  endtask

  task automatic run_and_time(input string name);
    @(posedge clk);
    start_mat_mul <= 1'b1;
    // start is sampled at this edge
    @(posedge clk);
    start_mat_mul <= 1'b0;
    @(posedge clk);
    lat = 1;
    @(negedge clk);
    check({name, " done low after start"}, 32'd0, 32'(done_mat_mul));
    while (!done_mat_mul)
    begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    check({name, " latency"}, 32'(`MM_LATENCY), 32'(lat));
  endtask

  // index is tile*16 + row*4 + col
  // anything above 63 reads element 63
  function automatic logic [31:0] expected_element(input int sel);
    int idx;
    int t;
    int row;
    int col;
    idx = (sel > N*N-1) ? N*N-1 : sel;
    t   = idx / (T*T);
    row = (idx / T) % T;
    col = idx % T;
    return ref_c[T*(t/G)+row][T*(t%G)+col];
  endfunction

  // one select per cycle with data_out one cycle behind
  task automatic read_results(input string name);
    int sel [N*N+1];
    for (int i = 0; i < N*N; i++)
    begin
      sel[i] = i;
    end
    sel[N*N] = 100;
    @(posedge clk);
    out_sel <= `MM_AWIDTH'(sel[0]);
    for (int i = 0; i < N*N+1; i++)
    begin
      @(posedge clk);
      if (i < N*N)
      begin
        out_sel <= `MM_AWIDTH'(sel[i+1]);
      end
      @(negedge clk);
      check($sformatf("%s out_sel %0d", name, sel[i]), expected_element(sel[i]), data_out);
    end
  endtask

  initial
  begin
    errors                = 0;
    checks                = 0;
    reset                 = 1'b1;
    enable_writing_to_mem = 1'b0;
    data_pi               = '0;
    addr_pi               = '0;
    we_a                  = 1'b0;
    we_b                  = 1'b0;
    out_sel               = '0;
    start_mat_mul         = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check("after reset done", 32'd0, 32'(done_mat_mul));
    check("after reset data_out", 32'd0, data_out);
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      build_model(a_pat[t], b_pat[t]);
      load_operands();
      run_and_time(test_name[t]);
      read_results(test_name[t]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: matmul_8x8.f
+incdir+logic
logic/matmul_pkg.sv
logic/operand_if.sv
logic/operand_ram.sv
logic/operand_feeder.sv
logic/systolic_tile.sv
logic/result_drain.sv
logic/matmul_8x8.sv
testbench/matmul_8x8_asserts.sv
testbench/matmul_8x8_tb.sv

// File: Makefile
TOP = matmul_8x8_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f matmul_8x8.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
